// File: include/hazard_defs.svh
`ifndef HAZARD_DEFS_SVH
`define HAZARD_DEFS_SVH

// Register index width, 32 GPRs
`define REG_W 5

// Word-index program counter width
`define PC_W 8

// Return address register written by JAL
`define LINK_REG (`REG_W'(31))

`endif

// File: verilog/hazardPkg.sv
`default_nettype none

package hazardPkg;

    `include "hazard_defs.svh"

    // ------------------------------------------------------------------------
    // Instruction encodings
    // ------------------------------------------------------------------------
    typedef enum logic [5:0] {
        SPECIAL = 6'h00,  // R-type, funct decides
        REGIMM  = 6'h01,
        J       = 6'h02,
        JAL     = 6'h03,
        BEQ     = 6'h04,
        BNE     = 6'h05,
        BLEZ    = 6'h06,
        BGTZ    = 6'h07,
        ADDI    = 6'h08,
        ADDIU   = 6'h09,
        SLTI    = 6'h0A,
        SLTIU   = 6'h0B,
        ANDI    = 6'h0C,
        ORI     = 6'h0D,
        XORI    = 6'h0E,
        LUI     = 6'h0F,
        LB      = 6'h20,
        LH      = 6'h21,
        LW      = 6'h23,
        LBU     = 6'h24,
        LHU     = 6'h25,
        LWU     = 6'h27,
        SB      = 6'h28,
        SH      = 6'h29,
        SW      = 6'h2B,
        HALT    = 6'h3F   // Stops fetch
    } opcodeE;

    // Only the jump functs matter to the hazard logic
    typedef enum logic [5:0] {
        OTHER = 6'h00,
        JR    = 6'h08,
        JALR  = 6'h09
    } functE;

    // Which field names the destination register
    typedef enum logic [1:0] {
        RT   = 2'b00,  // Immediate and load
        RD   = 2'b01,  // R-type
        LINK = 2'b10   // JAL, fixed $31
    } dstSelE;

    // ------------------------------------------------------------------------
    // Stage records
    // ------------------------------------------------------------------------
    typedef struct packed {
        opcodeE            opcode;
        functE             funct;
        logic [`REG_W-1:0] rs;
        logic [`REG_W-1:0] rt;
        logic [`REG_W-1:0] rd;
        logic              regWrite;
        logic              memRead;
        dstSelE            dstSel;
    } idInfoT;

    typedef struct packed {
        logic              regWrite;
        logic              memRead;
        dstSelE            dstSel;  // Still unresolved in EX
        logic [`REG_W-1:0] rt;
        logic [`REG_W-1:0] rd;
    } idExT;

    typedef struct packed {
        logic              regWrite;
        logic              memRead;
        logic [`REG_W-1:0] dst;
    } exMemT;

    typedef struct packed {
        logic              regWrite;
        logic [`REG_W-1:0] dst;
    } memWbT;

    typedef struct packed {
        logic pcWrite;
        logic ifIdWrite;
        logic controlStall;
        logic branchFlush;
        logic compareBranch;
    } hazardCtrlT;

    // Destination index picked by a dstSel code
    function automatic logic [`REG_W-1:0] resolveDst(
        input dstSelE            sel,
        input logic [`REG_W-1:0] rt,
        input logic [`REG_W-1:0] rd
    );
        case (sel)
            RT:      return rt;
            RD:      return rd;
            LINK:    return `LINK_REG;
            default: return rt;
        endcase
    endfunction

endpackage

`default_nettype wire

// File: verilog/instrDecoder.sv
`timescale 1ns/1ns
`default_nettype none

module instrDecoder (
    input  wire  [31:0]            instrId,
    output hazardPkg::idInfoT      idInfo
);

    logic [5:0]        functRaw;
    logic              writes;     // Instruction class writes a GPR
    hazardPkg::dstSelE sel;

    // ------------------------------------------------------------------------
    // Field split
    // ------------------------------------------------------------------------
    always_comb begin
        idInfo.opcode = hazardPkg::opcodeE'(instrId[31:26]);
        idInfo.rs     = instrId[25:21];
        idInfo.rt     = instrId[20:16];
        idInfo.rd     = instrId[15:11];
        functRaw      = instrId[5:0];

        // Collapse non-jump functs
        case (functRaw)
            6'h08:   idInfo.funct = hazardPkg::JR;
            6'h09:   idInfo.funct = hazardPkg::JALR;
            default: idInfo.funct = hazardPkg::OTHER;
        endcase
    end

    // ------------------------------------------------------------------------
    // Control class
    // ------------------------------------------------------------------------
    always_comb begin
        writes         = 1'b0;
        idInfo.memRead = 1'b0;
        sel            = hazardPkg::RT;

        case (idInfo.opcode)
            hazardPkg::SPECIAL: begin
                // JR writes nothing, JALR links into rd
                writes = (idInfo.funct != hazardPkg::JR);
                sel    = hazardPkg::RD;
            end
            hazardPkg::ADDI, hazardPkg::ADDIU, hazardPkg::SLTI, hazardPkg::SLTIU,
            hazardPkg::ANDI, hazardPkg::ORI, hazardPkg::XORI, hazardPkg::LUI: begin
                writes = 1'b1;  // Result into rt
            end
            hazardPkg::LB, hazardPkg::LH, hazardPkg::LW,
            hazardPkg::LBU, hazardPkg::LHU, hazardPkg::LWU: begin
                writes         = 1'b1;
                idInfo.memRead = 1'b1;
            end
            hazardPkg::JAL: begin
                writes = 1'b1;
                sel    = hazardPkg::LINK;
            end
            default: begin
                writes = 1'b0;  // Stores, branches, J, HALT
            end
        endcase

        idInfo.dstSel = sel;

        // Writes to $0 are dropped, so a NOP never raises a hazard
        idInfo.regWrite = writes &&
            (hazardPkg::resolveDst(sel, idInfo.rt, idInfo.rd) != '0);
    end

endmodule

`default_nettype wire

// File: verilog/stagePipe.sv
`timescale 1ns/1ns
`default_nettype none

module stagePipe (
    input  wire                    clk,
    input  wire                    rstN,
    input  wire hazardPkg::idInfoT idInfo,
    input  wire                    controlStall,
    output hazardPkg::idExT        idEx,
    output hazardPkg::exMemT       exMem,
    output hazardPkg::memWbT       memWb
);

    // ------------------------------------------------------------------------
    // ID/EX
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rstN) begin
            idEx <= '0;  // Bubble
        end else begin
            idEx.dstSel <= idInfo.dstSel;
            idEx.rt     <= idInfo.rt;
            idEx.rd     <= idInfo.rd;

            // Stall keeps the ID instruction, EX gets a bubble
            if (controlStall) begin
                idEx.regWrite <= 1'b0;
                idEx.memRead  <= 1'b0;
            end else begin
                idEx.regWrite <= idInfo.regWrite;
                idEx.memRead  <= idInfo.memRead;
            end
        end
    end

    // ------------------------------------------------------------------------
    // EX/MEM
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rstN) begin
            exMem <= '0;
        end else begin
            exMem.regWrite <= idEx.regWrite;
            exMem.memRead  <= idEx.memRead;
            // Destination becomes a plain index from here on
            exMem.dst      <= hazardPkg::resolveDst(idEx.dstSel, idEx.rt, idEx.rd);
        end
    end

    // ------------------------------------------------------------------------
    // MEM/WB
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rstN) begin
            memWb <= '0;
        end else begin
            memWb.regWrite <= exMem.regWrite;  // Load data lands here
            memWb.dst      <= exMem.dst;
        end
    end

endmodule

`default_nettype wire

// File: verilog/hazardUnit.sv
`timescale 1ns/1ns
`default_nettype none

module hazardUnit (
    input  wire hazardPkg::idInfoT idInfo,
    input  wire hazardPkg::idExT   idEx,
    input  wire hazardPkg::exMemT  exMem,
    input  wire hazardPkg::memWbT  memWb,
    output hazardPkg::hazardCtrlT  ctrl,
    output logic                   haltReq
);

    `include "hazard_defs.svh"

    logic              isBranch;
    logic              isJr;
    logic              isJump;
    logic [`REG_W-1:0] exDst;     // Resolved EX destination
    logic              exHit;     // EX writes an ID source
    logic              memHit;    // MEM writes an ID source
    logic              wbHit;     // WB writes an ID source
    logic              jrLinkHaz;
    logic              jrDataHaz;

    // ------------------------------------------------------------------------
    // Instruction classes and register matches
    // ------------------------------------------------------------------------
    always_comb begin
        isBranch = (idInfo.opcode == hazardPkg::BEQ)  ||
                   (idInfo.opcode == hazardPkg::BNE)  ||
                   (idInfo.opcode == hazardPkg::BLEZ) ||
                   (idInfo.opcode == hazardPkg::BGTZ);  // rt is $0 for the last two

        isJr = (idInfo.opcode == hazardPkg::SPECIAL) &&
               ((idInfo.funct == hazardPkg::JR) || (idInfo.funct == hazardPkg::JALR));

        isJump = (idInfo.opcode == hazardPkg::J) ||
                 (idInfo.opcode == hazardPkg::JAL) || isJr;

        exDst = hazardPkg::resolveDst(idEx.dstSel, idEx.rt, idEx.rd);

        exHit  = idEx.regWrite  && ((exDst == idInfo.rs) || (exDst == idInfo.rt));
        memHit = exMem.regWrite &&
                 ((exMem.dst == idInfo.rs) || (exMem.dst == idInfo.rt));
        wbHit  = memWb.regWrite &&
                 ((memWb.dst == idInfo.rs) || (memWb.dst == idInfo.rt));

        // JR $ra behind a JAL still in flight
        jrLinkHaz = (idInfo.funct == hazardPkg::JR) &&
                    ((idEx.regWrite && (idEx.dstSel == hazardPkg::LINK)) ||
                     (exMem.regWrite && (exMem.dst == `LINK_REG)));

        // Jump register source still being produced
        jrDataHaz = (idEx.regWrite && (exDst == idInfo.rs)) ||
                    (exMem.regWrite && (exMem.dst == idInfo.rs));
    end

    // ------------------------------------------------------------------------
    // Priority chain, first match wins
    // ------------------------------------------------------------------------
    always_comb begin
        // Default, pipeline flows
        ctrl.pcWrite       = 1'b1;
        ctrl.ifIdWrite     = 1'b1;
        ctrl.controlStall  = 1'b0;
        ctrl.branchFlush   = 1'b0;
        ctrl.compareBranch = 1'b0;

        if (isBranch && exHit) begin
            ctrl.pcWrite      = 1'b0;
            ctrl.ifIdWrite    = 1'b0;
            ctrl.controlStall = 1'b1;
            // Compare may run on forwarded EX result only if nothing older interferes
            ctrl.compareBranch = !wbHit && !exMem.memRead && !idEx.memRead;
        end else if (isBranch && exMem.memRead && memHit) begin
            // Load data not back until WB
            ctrl.pcWrite      = 1'b0;
            ctrl.ifIdWrite    = 1'b0;
            ctrl.controlStall = 1'b1;
        end else if (isBranch) begin
            ctrl.compareBranch = !exMem.memRead;  // No dependency
        end else if (idEx.memRead && exHit) begin
            // Classic load-use, one cycle
            ctrl.pcWrite      = 1'b0;
            ctrl.ifIdWrite    = 1'b0;
            ctrl.controlStall = 1'b1;
        end else if (isJr && (jrLinkHaz || jrDataHaz)) begin
            // Hold JR in ID until its register settles
            ctrl.pcWrite      = 1'b0;
            ctrl.ifIdWrite    = 1'b0;
            ctrl.controlStall = 1'b1;
        end else if (isJump) begin
            // Kill the fall-through fetch
            ctrl.ifIdWrite   = 1'b0;
            ctrl.branchFlush = 1'b1;
        end
    end

    assign haltReq = (idInfo.opcode == hazardPkg::HALT);

endmodule

`default_nettype wire

// File: verilog/fetchFront.sv
`timescale 1ns/1ns
`default_nettype none

`include "hazard_defs.svh"

module fetchFront (
    input  wire                        clk,
    input  wire                        rstN,
    input  wire  [31:0]                instrIf,  // From instruction memory
    input  wire  hazardPkg::hazardCtrlT ctrl,
    input  wire                        haltReq,
    output logic [`PC_W-1:0]           pc,
    output logic [31:0]                instrId
);

    hazardPkg::opcodeE opId;
    logic              directJump;  // J or JAL in ID
    logic              haltFlag;    // Sticky until reset
    logic              pcHold;

    always_comb begin
        opId       = hazardPkg::opcodeE'(instrId[31:26]);
        directJump = (opId == hazardPkg::J) || (opId == hazardPkg::JAL);
        pcHold     = !ctrl.pcWrite || haltFlag || haltReq;
    end

    // ------------------------------------------------------------------------
    // Program counter
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc       <= '0;
            haltFlag <= 1'b0;
        end else begin
            if (haltReq) begin
                haltFlag <= 1'b1;
            end
            if (!pcHold) begin
                if (ctrl.branchFlush && directJump) begin
                    pc <= instrId[`PC_W-1:0];  // Target index from low bits
                end else begin
                    pc <= pc + `PC_W'(1);      // Next word
                end
            end
        end
    end

    // ------------------------------------------------------------------------
    // IF/ID instruction register
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rstN) begin
            instrId <= '0;  // NOP
        end else if (ctrl.branchFlush) begin
            instrId <= '0;
        end else if (ctrl.ifIdWrite) begin
            instrId <= instrIf;
        end
    end

endmodule

`default_nettype wire

// File: verilog/pipeControl.sv
`timescale 1ns/1ns
`default_nettype none

`include "hazard_defs.svh"

module pipeControl (
    input  wire                   clk,
    input  wire                   rstN,
    input  wire  [31:0]           instrIf,
    output logic [`PC_W-1:0]      pc,
    output hazardPkg::hazardCtrlT ctrl,
    output logic                  halt
);

    logic [31:0]         instrId;  // IF/ID word
    hazardPkg::idInfoT   idInfo;
    hazardPkg::idExT     idEx;
    hazardPkg::exMemT    exMem;
    hazardPkg::memWbT    memWb;

    // ------------------------------------------------------------------------
    // Front end and decode
    // ------------------------------------------------------------------------
    fetchFront fetch0 (
        .clk     (clk),
        .rstN    (rstN),
        .instrIf (instrIf),
        .ctrl    (ctrl),
        .haltReq (halt),     // Halt also freezes the PC
        .pc      (pc),
        .instrId (instrId)
    );

    instrDecoder dec0 (
        .instrId (instrId),
        .idInfo  (idInfo)
    );

    // ------------------------------------------------------------------------
    // Shadow stages and hazard detection
    // ------------------------------------------------------------------------
    stagePipe pipe0 (
        .clk          (clk),
        .rstN         (rstN),
        .idInfo       (idInfo),
        .controlStall (ctrl.controlStall),
        .idEx         (idEx),
        .exMem        (exMem),
        .memWb        (memWb)
    );

    hazardUnit haz0 (
        .idInfo  (idInfo),
        .idEx    (idEx),
        .exMem   (exMem),
        .memWb   (memWb),
        .ctrl    (ctrl),
        .haltReq (halt)
    );

endmodule

`default_nettype wire

// File: testbench/tbPrograms.svh
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

// One entry per program, words from index 0, then the expected
// stall, flush and compare cycle counts, halt flag and pc after the first flush
task automatic buildPrograms();
    int i;
    for (i = 0; i < MAX_PROGS; i++) begin
        progLen[i] = 0;
    end
    progCount = 0;

    // Load-use, one bubble
    putWord(32'h8C220000);  // LW   $2, 0($1)
    putWord(32'h00441820);  // ADD  $3, $2, $4
    putWord(32'hFC000000);  // HALT
    closeEntry(1, 0, 0, 1'b1, 8'hFF);

    // Load then independent ADD
    putWord(32'h8C220000);  // LW   $2, 0($1)
    putWord(32'h00A41820);  // ADD  $3, $5, $4
    putWord(32'hFC000000);
    closeEntry(0, 0, 0, 1'b1, 8'hFF);

    // ALU result feeds BEQ, compare in the stall and again after it
    putWord(32'h00221820);  // ADD  $3, $1, $2
    putWord(32'h10640000);  // BEQ  $3, $4
    putWord(32'hFC000000);
    closeEntry(1, 0, 2, 1'b1, 8'hFF);

    // Load feeds BEQ, two bubbles, compare once the data is in WB
    putWord(32'h8C230000);  // LW   $3, 0($1)
    putWord(32'h10640000);  // BEQ  $3, $4
    putWord(32'hFC000000);
    closeEntry(2, 0, 1, 1'b1, 8'hFF);

    // Independent branch
    putWord(32'h00221820);  // ADD  $3, $1, $2
    putWord(32'h10A40000);  // BEQ  $5, $4
    putWord(32'hFC000000);
    closeEntry(0, 0, 1, 1'b1, 8'hFF);

    // JAL to 3, JR $31 waits for the link write to leave MEM
    putWord(32'h0C000003);  // JAL  3
    putWord(32'h00223020);  // Flushed
    putWord(32'h00223020);  // Skipped
    putWord(32'h03E00008);  // JR   $31
    putWord(32'h00223020);  // Flushed
    putWord(32'hFC000000);
    closeEntry(1, 2, 0, 1'b1, 8'h03);

    // Plain jump
    putWord(32'h08000004);  // J    4
    putWord(32'h00223020);
    putWord(32'h00223020);
    putWord(32'h00223020);
    putWord(32'hFC000000);  // Target
    closeEntry(0, 1, 0, 1'b1, 8'h04);

    // JR on a register still in EX, then MEM
    putWord(32'h00224020);  // ADD  $8, $1, $2
    putWord(32'h01000008);  // JR   $8
    putWord(32'h00223020);  // Flushed
    putWord(32'hFC000000);
    closeEntry(2, 1, 0, 1'b1, 8'h03);

    // Forwardable chain, no halt
    putWord(32'h00221820);  // ADD  $3, $1, $2
    putWord(32'h00613020);  // ADD  $6, $3, $1
    putWord(32'hAC260000);  // SW   $6, 0($1)
    closeEntry(0, 0, 0, 1'b0, 8'hFF);
endtask

`endif

// File: testbench/tbPipeControl.sv
`timescale 1ns/1ns
`default_nettype none

module tbPipeControl;

    `include "hazard_defs.svh"

    localparam int MAX_PROGS  = 12;
    localparam int MAX_WORDS  = 8;
    localparam int RST_CYCLES = 5;
    localparam int RUN_CYCLES = 16;
    localparam int MEM_WORDS  = 1 << `PC_W;

    logic                  clk;
    logic                  rstN;
    logic [31:0]           instrIf;
    logic [`PC_W-1:0]      pc;
    hazardPkg::hazardCtrlT ctrl;
    logic                  halt;

    // Program table
    logic [31:0]      progWords [MAX_PROGS][MAX_WORDS];
    int               progLen   [MAX_PROGS];
    int               expStall  [MAX_PROGS];
    int               expFlush  [MAX_PROGS];
    int               expCompare[MAX_PROGS];
    logic             expHalt   [MAX_PROGS];
    logic [`PC_W-1:0] expJumpPc [MAX_PROGS];  // 'hFF skips the target check
    int               progCount;

    logic [31:0] fillWords [MEM_WORDS];  // One filler word per pc

    logic [15:0] lfsrState;
    int          cycleCount;
    int          cycleLimit;
    int          errorCount;
    int          checkCount;
    int          e;

    pipeControl dut0 (
        .clk     (clk),
        .rstN    (rstN),
        .instrIf (instrIf),
        .pc      (pc),
        .ctrl    (ctrl),
        .halt    (halt)
    );

    always #2 clk = ~clk;  // 4 ns period

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
    end

    // ------------------------------------------------------------------------
    // Table building and filler words
    // ------------------------------------------------------------------------
    task automatic putWord(input logic [31:0] w);
        progWords[progCount][progLen[progCount]] = w;
        progLen[progCount] = progLen[progCount] + 1;
    endtask

    task automatic closeEntry(input int stalls, input int flushes, input int compares,
                              input logic halted, input logic [`PC_W-1:0] jumpPc);
        expStall[progCount]   = stalls;
        expFlush[progCount]   = flushes;
        expCompare[progCount] = compares;
        expHalt[progCount]    = halted;
        expJumpPc[progCount]  = jumpPc;
        progCount = progCount + 1;
    endtask

    `include "tbPrograms.svh"

    // Galois LFSR with taps x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsrNext(input logic [15:0] s);
        lfsrNext = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic randomBits(input int n, output logic [7:0] bits);
        int i;
        bits = '0;
        for (i = 0; i < n; i++) begin
            lfsrState = lfsrNext(lfsrState);  // One step per bit
            bits      = {bits[6:0], lfsrState[0]};
        end
    endtask

    // SLL into $0 reading only $16..$23 that no test uses
    task automatic buildFiller();
        int         a;
        logic [7:0] rsBits;
        logic [7:0] rtBits;
        for (a = 0; a < MEM_WORDS; a++) begin
            randomBits(3, rsBits);
            randomBits(3, rtBits);
            fillWords[a] = {6'h00, 2'b10, rsBits[2:0], 2'b10, rtBits[2:0], 16'h0000};
        end
    endtask

    // Instruction memory read with filler past the program end
    task automatic fetchWord(input int prog, output logic [31:0] w);
        if (pc < progLen[prog]) begin
            w = progWords[prog][pc];
        end else begin
            w = fillWords[pc];
        end
    endtask

    task automatic applyReset();
        rstN = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        #1;
        rstN = 1'b1;
    endtask

    // ------------------------------------------------------------------------
    // One program with strobe counts and pc checks
    // ------------------------------------------------------------------------
    task automatic runProgram(input int prog);
        int               cyc;
        int               stallCnt;
        int               flushCnt;
        int               compareCnt;
        logic             haltSeen;
        logic [`PC_W-1:0] haltPc;
        logic             prevHold;
        logic             prevFlush;
        logic             jumpDone;
        logic [`PC_W-1:0] prevPc;
        stallCnt   = 0;
        flushCnt   = 0;
        compareCnt = 0;
        haltSeen   = 1'b0;
        haltPc     = '0;
        prevHold   = 1'b0;
        prevFlush  = 1'b0;
        jumpDone   = 1'b0;
        prevPc     = '0;
        for (cyc = 0; cyc < RUN_CYCLES; cyc++) begin
            fetchWord(prog, instrIf);
            @(negedge clk);  // Strobes settled
            if (cyc == 0) begin
                checkCount = checkCount + 2;
                if (ctrl !== 5'b11000) begin  // Only pcWrite and ifIdWrite high
                    errorCount++;
                    $display("FAILED prog %0d: ctrl after reset 0x%0h expected 0x18",
                             prog, ctrl);
                end
                if (pc !== '0) begin
                    errorCount++;
                    $display("FAILED prog %0d: pc after reset 0x%0h expected 0x0", prog, pc);
                end
            end
            // A stall cycle must have left the pc where it was
            if (prevHold) begin
                checkCount++;
                if (pc !== prevPc) begin
                    errorCount++;
                    $display("FAILED prog %0d cycle %0d: pc 0x%0h expected 0x%0h",
                             prog, cyc, pc, prevPc);
                end
            end
            if (haltSeen) begin
                checkCount++;
                if (pc !== haltPc) begin
                    errorCount++;
                    $display("FAILED prog %0d cycle %0d: pc 0x%0h expected 0x%0h",
                             prog, cyc, pc, haltPc);
                end
            end
            // pc right after the first flush
            if (prevFlush && !jumpDone) begin
                jumpDone = 1'b1;
                if (expJumpPc[prog] != 8'hFF) begin
                    checkCount++;
                    if (pc !== expJumpPc[prog]) begin
                        errorCount++;
                        $display("FAILED prog %0d: pc 0x%0h expected 0x%0h",
                                 prog, pc, expJumpPc[prog]);
                    end
                end
            end
            if (ctrl.controlStall) begin
                stallCnt++;
                checkCount++;
                // PC and IF/ID both frozen in a stall
                if (ctrl.pcWrite || ctrl.ifIdWrite) begin
                    errorCount++;
                    $display("FAILED prog %0d cycle %0d: pcWrite,ifIdWrite 0x%0h expected 0x0",
                             prog, cyc, {ctrl.pcWrite, ctrl.ifIdWrite});
                end
            end
            if (ctrl.branchFlush) flushCnt++;
            if (ctrl.compareBranch) compareCnt++;
            if (halt && !haltSeen) begin
                haltSeen = 1'b1;
                haltPc   = pc;  // Frozen from the next clock on
            end
            prevHold  = ctrl.controlStall;
            prevFlush = ctrl.branchFlush;
            prevPc    = pc;
            @(posedge clk);
            #1;  // Drive after the edge
        end

        checkCount = checkCount + 4;
        if (stallCnt != expStall[prog]) begin
            errorCount++;
            $display("FAILED prog %0d: controlStall cycles 0x%0h expected 0x%0h",
                     prog, stallCnt, expStall[prog]);
        end
        if (flushCnt != expFlush[prog]) begin
            errorCount++;
            $display("FAILED prog %0d: branchFlush cycles 0x%0h expected 0x%0h",
                     prog, flushCnt, expFlush[prog]);
        end
        if (compareCnt != expCompare[prog]) begin
            errorCount++;
            $display("FAILED prog %0d: compareBranch cycles 0x%0h expected 0x%0h",
                     prog, compareCnt, expCompare[prog]);
        end
        if (haltSeen !== expHalt[prog]) begin
            errorCount++;
            $display("FAILED prog %0d: halt 0x%0h expected 0x%0h",
                     prog, haltSeen, expHalt[prog]);
        end
    endtask

    // ------------------------------------------------------------------------
    // Main sequence and watchdog
    // ------------------------------------------------------------------------
    initial begin
        clk        = 1'b0;
        rstN       = 1'b0;
        instrIf    = '0;
        lfsrState  = 16'd63;
        cycleCount = 0;
        errorCount = 0;
        checkCount = 0;
        buildPrograms();
        buildFiller();
        cycleLimit = progCount * (RST_CYCLES + RUN_CYCLES) + 20;

        @(posedge clk);
        #1;
        for (e = 0; e < progCount; e++) begin
            applyReset();
            runProgram(e);
        end

        $display("Done: %0d programs, %0d checks, %0d errors",
                 progCount, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    initial begin
        @(posedge clk);
        while (cycleCount < cycleLimit) @(posedge clk);
        $display("Timeout: run did not finish within %0d cycles", cycleLimit);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
+incdir+include
+incdir+testbench
verilog/hazardPkg.sv
verilog/instrDecoder.sv
verilog/stagePipe.sv
verilog/hazardUnit.sv
verilog/fetchFront.sv
verilog/pipeControl.sv
testbench/tbPipeControl.sv

// File: Bender.yml
package:
  name: pipe_control

sources:
  - include_dirs:
      - include
    files:
      - verilog/hazardPkg.sv
      - verilog/instrDecoder.sv
      - verilog/stagePipe.sv
      - verilog/hazardUnit.sv
      - verilog/fetchFront.sv
      - verilog/pipeControl.sv
  - target: simulation
    include_dirs:
      - include
      - testbench
    files:
      - testbench/tbPipeControl.sv
